//--- common/dcache_pkg.sv
package dcache_pkg;

    // tile geometry
    localparam int DATA_W     = 16;
    localparam int DEPTH      = 16;   // rows, also the column length
    localparam int IDX_W      = 4;    // row or column index
    localparam int DDR_ADDR_W = 28;   // DDR word address

    // command opcodes as seen on cmd
    typedef enum logic [2:0] {
        CMD_NONE    = 3'd0,
        CMD_ROW_PUT = 3'd1,
        CMD_ROW_GET = 3'd2,
        CMD_COL_PUT = 3'd3,
        CMD_COL_GET = 3'd4,
        CMD_STORE   = 3'd5,
        CMD_FILL    = 3'd6
    } cmd_e;

    // controller states
    // put and get each take one working state before ST_DONE
    typedef enum logic [3:0] {
        ST_IDLE      = 4'd0,
        ST_ROW_PUT   = 4'd1,
        ST_COL_PUT   = 4'd2,
        ST_ROW_GET   = 4'd3,
        ST_COL_GET   = 4'd4,
        ST_STORE     = 4'd5,   // one row index issued per store_en cycle
        ST_STORE_END = 4'd6,   // last store word on the DDR port
        ST_FILL      = 4'd7,   // one row written per fill_valid
        ST_DONE      = 4'd8    // cache_rdy pulse
    } state_e;

endpackage

//--- hw/cache_row.sv
`timescale 1ns/1ps

module cache_row import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              word_we,    // whole-word write
    input  logic [DATA_W-1:0] word_in,
    input  logic              bit_we,     // column write, one bit only
    input  logic              bit_in,
    input  logic [IDX_W-1:0]  col,
    output logic [DATA_W-1:0] word_out
);

    // word and bit writes never come in the same cycle,
    // a word write still wins if they ever did
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            word_out <= '0;
        end else if (word_we) begin
            word_out <= word_in;
        end else if (bit_we) begin
            word_out[col] <= bit_in;   // rest of the row untouched
        end
    end

endmodule

//--- hw/read_mux.sv
`timescale 1ns/1ps

module read_mux import dcache_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [DEPTH*DATA_W-1:0] rows,      // row r at bits r*DATA_W upward
    input  logic [IDX_W-1:0]        row_sel,
    input  logic [IDX_W-1:0]        col,
    input  logic                    capture_row,
    input  logic                    capture_col,
    input  logic                    capture_store,
    output logic [DATA_W-1:0]       data_rbr_out,
    output logic [DEPTH-1:0]        data_cbc_out,
    output logic [DATA_W-1:0]       ddr_wr_data
);

    logic [DATA_W-1:0] row_arr [DEPTH];
    logic [DATA_W-1:0] sel_word;
    logic [DEPTH-1:0]  col_bits;

    for (genvar r = 0; r < DEPTH; r++) begin : g_unpack
        assign row_arr[r] = rows[r*DATA_W +: DATA_W];
    end

    assign sel_word = row_arr[row_sel];

    // bit col of every row, row 0 in bit 0
    always_comb begin
        for (int r = 0; r < DEPTH; r++) begin
            col_bits[r] = row_arr[r][col];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            data_rbr_out <= '0;
            data_cbc_out <= '0;
            ddr_wr_data  <= '0;
        end else begin
            if (capture_row) begin
                data_rbr_out <= sel_word;   // held until the next row get
            end
            if (capture_col) begin
                data_cbc_out <= col_bits;
            end
            if (capture_store) begin
                ddr_wr_data <= sel_word;    // row_sel follows the burst count here
            end
        end
    end

endmodule

//--- hw/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  cmd_e                  cmd,
    input  logic                  cmd_valid,
    input  logic [IDX_W-1:0]      row_addr,
    input  logic [IDX_W-1:0]      col_addr,
    input  logic [DDR_ADDR_W-1:0] ddr_base,
    input  logic                  store_en,
    input  logic                  fill_valid,
    input  logic [DATA_W-1:0]     fill_data,
    input  logic [DATA_W-1:0]     data_rbr_in,
    output logic [DEPTH-1:0]      word_we,
    output logic [DEPTH-1:0]      bit_we,
    output logic [DATA_W-1:0]     wr_word,
    output logic [IDX_W-1:0]      col,
    output logic [IDX_W-1:0]      row_sel,
    output logic                  capture_row,
    output logic                  capture_col,
    output logic                  capture_store,
    output logic                  cache_rdy,
    output logic                  store_req,
    output logic                  ddr_wr_valid,
    output logic [DDR_ADDR_W-1:0] ddr_wr_addr,
    output logic                  read_req,
    output logic [DDR_ADDR_W-1:0] ddr_rd_addr
);

    state_e                  state;
    state_e                  state_nxt;
    logic [IDX_W-1:0]        row_q;
    logic [IDX_W-1:0]        col_q;
    logic [DDR_ADDR_W-1:0]   base_q;
    logic [IDX_W-1:0]        row_cnt;    // shared by store burst and fill
    logic                    last_row;

    assign last_row = (row_cnt == IDX_W'(DEPTH - 1));

    // the opcode is held in the state register from the accept edge on
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (cmd_valid) begin
                    case (cmd)
                        CMD_ROW_PUT: state_nxt = ST_ROW_PUT;
                        CMD_ROW_GET: state_nxt = ST_ROW_GET;
                        CMD_COL_PUT: state_nxt = ST_COL_PUT;
                        CMD_COL_GET: state_nxt = ST_COL_GET;
                        CMD_STORE:   state_nxt = ST_STORE;
                        CMD_FILL:    state_nxt = ST_FILL;
                        default:     state_nxt = ST_DONE;   // nop still completes
                    endcase
                end
            end
            ST_ROW_PUT, ST_COL_PUT, ST_ROW_GET, ST_COL_GET: state_nxt = ST_DONE;
            ST_STORE: begin
                if (store_en && last_row) state_nxt = ST_STORE_END;
            end
            ST_STORE_END: state_nxt = ST_DONE;
            ST_FILL: begin
                if (fill_valid && last_row) state_nxt = ST_DONE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state  <= ST_IDLE;
            row_q  <= '0;
            col_q  <= '0;
            base_q <= '0;
        end else begin
            state <= state_nxt;
            if (state == ST_IDLE && cmd_valid) begin   // operands latched at accept
                row_q  <= row_addr;
                col_q  <= col_addr;
                base_q <= ddr_base;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            row_cnt <= '0;
        end else if (state == ST_IDLE) begin
            row_cnt <= '0;
        end else if ((state == ST_STORE && store_en) || (state == ST_FILL && fill_valid)) begin
            row_cnt <= row_cnt + 1'b1;   // wraps to 0 after row 15
        end
    end

    // one-hot word writes for row put and fill
    always_comb begin
        word_we = '0;
        if (state == ST_ROW_PUT) begin
            word_we[row_q] = 1'b1;
        end else if (state == ST_FILL && fill_valid) begin
            word_we[row_cnt] = 1'b1;
        end
    end

    assign bit_we  = {DEPTH{state == ST_COL_PUT}};   // every row takes its own bit
    assign wr_word = (state == ST_FILL) ? fill_data : data_rbr_in;
    assign col     = col_q;
    assign row_sel = (state == ST_STORE) ? row_cnt : row_q;

    assign capture_row   = (state == ST_ROW_GET);
    assign capture_col   = (state == ST_COL_GET);
    assign capture_store = (state == ST_STORE) && store_en;

    // one cycle behind the issue, in step with the registered store word
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ddr_wr_valid <= 1'b0;
            ddr_wr_addr  <= '0;
        end else begin
            ddr_wr_valid <= capture_store;
            if (capture_store) begin
                ddr_wr_addr <= base_q + DDR_ADDR_W'(row_cnt);
            end
        end
    end

    assign store_req   = (state == ST_STORE) || (state == ST_STORE_END);
    assign read_req    = (state == ST_FILL);
    assign ddr_rd_addr = base_q;
    assign cache_rdy   = (state == ST_DONE);

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  cmd_e                  cmd,
    input  logic                  cmd_valid,
    input  logic [IDX_W-1:0]      row_addr,
    input  logic [IDX_W-1:0]      col_addr,
    input  logic [DDR_ADDR_W-1:0] ddr_base,
    input  logic [DATA_W-1:0]     data_rbr_in,
    input  logic [DEPTH-1:0]      data_cbc_in,
    input  logic                  store_en,
    input  logic                  fill_valid,
    input  logic [DATA_W-1:0]     fill_data,
    output logic                  cache_rdy,
    output logic [DATA_W-1:0]     data_rbr_out,
    output logic [DEPTH-1:0]      data_cbc_out,
    output logic                  store_req,
    output logic                  ddr_wr_valid,
    output logic [DDR_ADDR_W-1:0] ddr_wr_addr,
    output logic [DATA_W-1:0]     ddr_wr_data,
    output logic                  read_req,
    output logic [DDR_ADDR_W-1:0] ddr_rd_addr
);

    logic [DEPTH-1:0]        word_we;
    logic [DEPTH-1:0]        bit_we;
    logic [DATA_W-1:0]       wr_word;
    logic [IDX_W-1:0]        col;
    logic [IDX_W-1:0]        row_sel;
    logic                    capture_row;
    logic                    capture_col;
    logic                    capture_store;
    logic [DEPTH*DATA_W-1:0] rows;   // flat bus of all row words

    dcache_ctrl ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .row_addr      (row_addr),
        .col_addr      (col_addr),
        .ddr_base      (ddr_base),
        .store_en      (store_en),
        .fill_valid    (fill_valid),
        .fill_data     (fill_data),
        .data_rbr_in   (data_rbr_in),
        .word_we       (word_we),
        .bit_we        (bit_we),
        .wr_word       (wr_word),
        .col           (col),
        .row_sel       (row_sel),
        .capture_row   (capture_row),
        .capture_col   (capture_col),
        .capture_store (capture_store),
        .cache_rdy     (cache_rdy),
        .store_req     (store_req),
        .ddr_wr_valid  (ddr_wr_valid),
        .ddr_wr_addr   (ddr_wr_addr),
        .read_req      (read_req),
        .ddr_rd_addr   (ddr_rd_addr)
    );

    // column put bit i lands in row i
    for (genvar i = 0; i < DEPTH; i++) begin : g_row
        cache_row row_i (
            .clk      (clk),
            .rst      (rst),
            .word_we  (word_we[i]),
            .word_in  (wr_word),
            .bit_we   (bit_we[i]),
            .bit_in   (data_cbc_in[i]),
            .col      (col),
            .word_out (rows[i*DATA_W +: DATA_W])
        );
    end

    read_mux mux_i (
        .clk           (clk),
        .rst           (rst),
        .rows          (rows),
        .row_sel       (row_sel),
        .col           (col),
        .capture_row   (capture_row),
        .capture_col   (capture_col),
        .capture_store (capture_store),
        .data_rbr_out  (data_rbr_out),
        .data_cbc_out  (data_cbc_out),
        .ddr_wr_data   (ddr_wr_data)
    );

endmodule

//--- verification/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    // reset low for the first 10 rising edges
    initial begin
        rst = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

//--- verification/dcache_assert.sv
`timescale 1ns/1ps

module dcache_assert import dcache_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input cmd_e                  cmd,
    input logic                  cmd_valid,
    input logic [IDX_W-1:0]      row_addr,
    input logic [IDX_W-1:0]      col_addr,
    input logic [DDR_ADDR_W-1:0] ddr_base,
    input logic [DATA_W-1:0]     data_rbr_in,
    input logic [DEPTH-1:0]      data_cbc_in,
    input logic                  store_en,
    input logic                  fill_valid,
    input logic [DATA_W-1:0]     fill_data,
    input logic                  cache_rdy,
    input logic [DATA_W-1:0]     data_rbr_out,
    input logic [DEPTH-1:0]      data_cbc_out,
    input logic                  store_req,
    input logic                  ddr_wr_valid,
    input logic [DDR_ADDR_W-1:0] ddr_wr_addr,
    input logic [DATA_W-1:0]     ddr_wr_data,
    input logic                  read_req,
    input logic [DDR_ADDR_W-1:0] ddr_rd_addr
);

    logic [DATA_W-1:0]     shadow [DEPTH];   // expected tile contents
    logic [DEPTH-1:0]      col_word;
    logic                  pending;          // accept edge up to the cache_rdy edge
    logic                  first;            // cycle 1 of a command
    cmd_e                  op_q;
    logic [IDX_W-1:0]      row_q;
    logic [IDX_W-1:0]      col_q;
    logic [DDR_ADDR_W-1:0] base_q;
    logic [IDX_W:0]        wr_idx;           // store words seen so far
    logic [IDX_W:0]        fill_idx;
    logic                  accept;
    logic                  short_op;
    logic                  fill_busy;
    int                    fail_cnt = 0;

    assign accept    = cmd_valid && !pending;
    assign short_op  = op_q inside {CMD_ROW_PUT, CMD_ROW_GET, CMD_COL_PUT, CMD_COL_GET};
    assign fill_busy = pending && (op_q == CMD_FILL) && !cache_rdy;

    always_comb begin
        for (int r = 0; r < DEPTH; r++) begin
            col_word[r] = shadow[r][col_q];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pending  <= 1'b0;
            first    <= 1'b0;
            op_q     <= CMD_NONE;
            row_q    <= '0;
            col_q    <= '0;
            base_q   <= '0;
            wr_idx   <= '0;
            fill_idx <= '0;
            for (int r = 0; r < DEPTH; r++) begin
                shadow[r] <= '0;
            end
        end else begin
            first <= accept;
            if (accept) begin
                pending  <= 1'b1;
                op_q     <= cmd;
                row_q    <= row_addr;
                col_q    <= col_addr;
                base_q   <= ddr_base;
                wr_idx   <= '0;
                fill_idx <= '0;
            end else if (cache_rdy) begin
                pending <= 1'b0;
            end
            // puts land at the end of cycle 1
            if (first && op_q == CMD_ROW_PUT) begin
                shadow[row_q] <= data_rbr_in;
            end
            if (first && op_q == CMD_COL_PUT) begin
                for (int r = 0; r < DEPTH; r++) begin
                    shadow[r][col_q] <= data_cbc_in[r];
                end
            end
            if (fill_busy && fill_valid) begin
                shadow[fill_idx[IDX_W-1:0]] <= fill_data;
                fill_idx <= fill_idx + 1'b1;
            end
            if (ddr_wr_valid) begin
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    task automatic note_failure(input string msg);
        fail_cnt++;
        $error("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    a_idle: assert property (@(posedge clk) disable iff (!rst)
        !pending |-> !(cache_rdy || store_req || read_req || ddr_wr_valid))
        else note_failure("output active with no command open");

    a_short: assert property (@(posedge clk) disable iff (!rst)
        pending && short_op |-> cache_rdy == $past(first))
        else note_failure("put or get not done 2 cycles after accept");

    a_row_get: assert property (@(posedge clk) disable iff (!rst)
        cache_rdy && op_q == CMD_ROW_GET |-> data_rbr_out == shadow[row_q])
        else note_failure("data_rbr_out differs from expected row");

    a_col_get: assert property (@(posedge clk) disable iff (!rst)
        cache_rdy && op_q == CMD_COL_GET |-> data_cbc_out == col_word)
        else note_failure("data_cbc_out differs from expected column");

    // one word per issue cycle, in row order, never while paused
    a_store_word: assert property (@(posedge clk) disable iff (!rst)
        ddr_wr_valid |-> op_q == CMD_STORE && $past(store_en && store_req)
            && ddr_wr_addr == base_q + DDR_ADDR_W'(wr_idx)
            && ddr_wr_data == shadow[wr_idx[IDX_W-1:0]])
        else note_failure("wrong or unexpected store word");

    a_store_shape: assert property (@(posedge clk) disable iff (!rst)
        pending && op_q == CMD_STORE |->
            (cache_rdy ? (!store_req && wr_idx == (IDX_W+1)'(DEPTH)) : store_req))
        else note_failure("store_req or store word count wrong");

    a_fill_shape: assert property (@(posedge clk) disable iff (!rst)
        pending && op_q == CMD_FILL |->
            (cache_rdy ? fill_idx == (IDX_W+1)'(DEPTH)
                       : (fill_idx < (IDX_W+1)'(DEPTH) && read_req && ddr_rd_addr == base_q)))
        else note_failure("read_req, ddr_rd_addr or fill completion wrong");

endmodule

bind dcache_top dcache_assert assert_i (.*);

//--- verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    logic                  clk;
    logic                  rst;
    cmd_e                  cmd;
    logic                  cmd_valid;
    logic [IDX_W-1:0]      row_addr;
    logic [IDX_W-1:0]      col_addr;
    logic [DDR_ADDR_W-1:0] ddr_base;
    logic [DATA_W-1:0]     data_rbr_in;
    logic [DEPTH-1:0]      data_cbc_in;
    logic                  store_en;
    logic                  fill_valid;
    logic [DATA_W-1:0]     fill_data;
    logic                  cache_rdy;
    logic [DATA_W-1:0]     data_rbr_out;
    logic [DEPTH-1:0]      data_cbc_out;
    logic                  store_req;
    logic                  ddr_wr_valid;
    logic [DDR_ADDR_W-1:0] ddr_wr_addr;
    logic [DATA_W-1:0]     ddr_wr_data;
    logic                  read_req;
    logic [DDR_ADDR_W-1:0] ddr_rd_addr;

    int short_budget = 4;           // cycles from accept to cache_rdy, with slack
    int burst_budget = 8 * DEPTH;   // store and fill under random pacing
    int n_short      = 42;          // puts and gets over all tests
    int n_burst      = 2;
    int timeouts     = 0;
    int n_tests      = 0;
    int fails_before = 0;

    clk_gen clk_i (.clk(clk), .rst(rst));

    dcache_top dut_i (.*);

    function automatic int failures();
        return dut_i.assert_i.fail_cnt + timeouts;
    endfunction

    // issue one command, then pace store_en and fill_valid until cache_rdy
    task automatic run_cmd(input cmd_e op, input logic [IDX_W-1:0] r,
                           input logic [IDX_W-1:0] c, input logic [DDR_ADDR_W-1:0] base);
        int cycles;
        int budget;
        logic rdy;
        cycles = 0;
        rdy    = 1'b0;
        budget = (op == CMD_STORE || op == CMD_FILL) ? burst_budget : short_budget;
        @(posedge clk);
        cmd        <= op;
        cmd_valid  <= 1'b1;
        row_addr   <= r;
        col_addr   <= c;
        ddr_base   <= base;
        store_en   <= 1'b0;
        fill_valid <= 1'b0;
        if (op == CMD_ROW_PUT) begin
            data_rbr_in <= DATA_W'($urandom);
        end
        if (op == CMD_COL_PUT) begin
            data_cbc_in <= DEPTH'($urandom);
        end
        while (!rdy && cycles < budget) begin
            @(posedge clk);
            cmd_valid  <= 1'b0;
            store_en   <= (op == CMD_STORE) && $urandom_range(0, 1);
            fill_valid <= (op == CMD_FILL) && $urandom_range(0, 1);
            fill_data  <= DATA_W'($urandom);
            @(negedge clk);
            rdy = cache_rdy;
            cycles++;
        end
        if (!rdy) begin
            timeouts++;
            $display("no cache_rdy within %0d cycles for %s", budget, op.name());
        end
    endtask

    task automatic end_test(input string name);
        int now;
        @(negedge clk);   // let the assertions of the last cycle fire
        now = failures();
        n_tests++;
        $display("test %0d %-6s %0d failures", n_tests, name, now - fails_before);
        fails_before = now;
    endtask

    initial begin
        logic [IDX_W-1:0] idx;
        void'($urandom(86));
        cmd         <= CMD_NONE;
        cmd_valid   <= 1'b0;
        row_addr    <= '0;
        col_addr    <= '0;
        ddr_base    <= '0;
        data_rbr_in <= '0;
        data_cbc_in <= '0;
        store_en    <= 1'b0;
        fill_valid  <= 1'b0;
        fill_data   <= '0;
        wait (rst);

        repeat (4) run_cmd(CMD_ROW_GET, IDX_W'($urandom), '0, '0);
        end_test("reset");

        repeat (6) begin
            idx = IDX_W'($urandom);
            run_cmd(CMD_ROW_PUT, idx, '0, '0);
            run_cmd(CMD_ROW_GET, idx, '0, '0);
        end
        end_test("row");

        repeat (3) begin
            idx = IDX_W'($urandom);
            run_cmd(CMD_COL_PUT, '0, idx, '0);
            run_cmd(CMD_COL_GET, '0, idx, '0);
        end
        repeat (4) run_cmd(CMD_ROW_GET, IDX_W'($urandom), '0, '0);   // merged column bits
        end_test("column");

        run_cmd(CMD_STORE, '0, '0, DDR_ADDR_W'($urandom));
        end_test("store");

        run_cmd(CMD_FILL, '0, '0, DDR_ADDR_W'($urandom));
        for (int i = 0; i < DEPTH; i++) begin
            run_cmd(CMD_ROW_GET, IDX_W'(i), '0, '0);
        end
        end_test("fill");

        $display("%0d tests, %0d assertion failures, %0d timeouts",
                 n_tests, dut_i.assert_i.fail_cnt, timeouts);
        if (failures() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // reset, then every command with its issue and idle cycles, doubled
    initial begin
        int wd_cycles;
        wd_cycles = 2 * (10 + n_short * (short_budget + 2) + n_burst * (burst_budget + 2));
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", wd_cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- compile.f
common/dcache_pkg.sv
hw/cache_row.sv
hw/read_mux.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verification/clk_gen.sv
verification/dcache_assert.sv
verification/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the dcache testbench with Verilator, run it and grep the log for the verdict
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module dcache_tb -f compile.f \
    && ./obj_dir/Vdcache_tb +verilator+error+limit+1000 2>&1 | tee sim.log \
    || echo "build or simulation stopped with an error"

grep -qx "Regression passed" sim.log && exit 0 || exit 1
